/* sources.f */
design/mmio_pkg.sv
design/data_ram.sv
design/spi_cmd_port.sv
design/touch_capture.sv
design/mmio_decoder.sv
design/mmio_top.sv
tests/mmio_decoder_asserts.sv
tests/mmio_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with verilator, result goes to sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module mmio_tb -f sources.f -o mmio_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/mmio_sim > sim.log 2>&1 || { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && { echo "failure found in sim.log"; exit 1; }
echo "no failure found in sim.log"
exit 0

/* tests/mmio_tb.sv */
`timescale 1ns/1ps

module mmio_tb;

    import mmio_pkg::*;

    logic        clk = 1'b0;
    logic        nRst;
    mh_req_t     req;
    logic [31:0] i2c_xy;
    logic        i2c_done;
    logic [31:0] rd_data;
    logic        busy;
    logic        touch_ready;
    logic        spi_sclk;
    logic        spi_mosi;
    logic        spi_cs_n;

    integer      seed = 32'h8471;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    logic [31:0] ram_model [MEM_WORDS];
    logic [63:0] spi_bits = '0;     // mosi history with the newest bit in bit 0
    int          spi_nbits = 0;
    int          frame_count = 0;

    always #5 clk = ~clk;

    mmio_top UUT (
        .clk           (clk),
        .nRst          (nRst),
        .req_i         (req),
        .i2c_xy_i      (i2c_xy),
        .i2c_done_i    (i2c_done),
        .rd_data_o     (rd_data),
        .busy_o        (busy),
        .touch_ready_o (touch_ready),
        .spi_sclk_o    (spi_sclk),
        .spi_mosi_o    (spi_mosi),
        .spi_cs_n_o    (spi_cs_n)
    );

    // spi receiver sampling on sclk rising
    always @(posedge spi_sclk) begin
        if (!spi_cs_n) begin
            spi_bits  = {spi_bits[62:0], spi_mosi};
            spi_nbits = spi_nbits + 1;
        end
    end

    always @(negedge spi_cs_n) frame_count = frame_count + 1;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs0);
        tests++;
        $display("test %s finished with %0d error(s)", name, errors - errs0);
    endtask

    // one command, then follow busy until it falls
    task automatic bus_access(input logic is_read, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int busy_cycles);
        int waited;
        waited      = 0;
        rdata       = '0;
        busy_cycles = 0;
        while (busy && waited < 50) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (busy) begin
            $display("timeout: busy never fell before the access to %h", addr);
            errors++;
        end
        req.read    = is_read;
        req.write   = !is_read;
        req.address = addr;
        req.data    = wdata;
        @(posedge clk);
        #1;
        req    = '0;
        waited = 0;
        while (busy && waited < 50) begin
            busy_cycles++;
            rdata = rd_data;    // last busy cycle holds the read word
            @(posedge clk);
            #1;
            waited++;
        end
        if (busy) begin
            $display("timeout: busy stayed high after the access to %h", addr);
            errors++;
        end
    endtask

    task automatic wait_frame_end();
        int waited;
        waited = 0;
        while (!spi_cs_n && waited < 200) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!spi_cs_n) begin
            $display("timeout: spi chip select never returned high");
            errors++;
        end
    endtask

    task automatic reset_state();
        int errs0;
        errs0 = errors;
        check_value("busy_o", 64'(busy), 64'd0);
        check_value("touch_ready_o", 64'(touch_ready), 64'd0);
        check_value("spi_sclk_o", 64'(spi_sclk), 64'd0);
        check_value("spi_cs_n_o", 64'(spi_cs_n), 64'd1);
        check_value("rd_data_o", 64'(rd_data), 64'd0);
        report_test("reset", errs0);
    endtask

    task automatic ram_roundtrip();
        logic [31:0] addrs [8];
        logic [31:0] rdata;
        int          cycles;
        int          errs0;
        errs0 = errors;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = $random(seed) & (MEM_WORDS - 1);
            ram_model[addrs[i][MEM_AW-1:0]] = $random(seed);
            bus_access(1'b0, addrs[i], ram_model[addrs[i][MEM_AW-1:0]], rdata, cycles);
            check_value("write busy cycles", 64'(cycles), 64'd1);
            @(posedge clk);     // let the ram busy pulse pass
            #1;
        end
        for (int i = 0; i < 8; i++) begin
            bus_access(1'b1, addrs[i], 32'h0, rdata, cycles);
            check_value("read busy cycles", 64'(cycles), 64'd2);
            check_value("rd_data_o", 64'(rdata), 64'(ram_model[addrs[i][MEM_AW-1:0]]));
        end
        report_test("ram", errs0);
    endtask

    task automatic spi_frame();
        logic [7:0]  cmd;
        logic [31:0] param;
        logic [39:0] frame;
        logic [63:0] mask;
        logic [31:0] rdata;
        int          cycles;
        int          nbits0;
        int          frames0;
        int          n;
        int          errs0;
        errs0 = errors;
        for (int cnt = 0; cnt <= 4; cnt++) begin
            cmd     = 8'($random(seed));
            param   = $random(seed);
            frame   = {cmd, param};
            n       = 8 + 8 * cnt;
            nbits0  = spi_nbits;
            frames0 = frame_count;
            // reserved bits set and ignored by the decoder
            bus_access(1'b0, SPI_CMD_ADDR, {20'hc3a5f, 4'(cnt), cmd}, rdata, cycles);
            bus_access(1'b0, SPI_PARAM_ADDR, param, rdata, cycles);
            check_value("spi_cs_n_o", 64'(spi_cs_n), 64'd0);
            if (cnt == 2) begin
                bus_access(1'b0, SPI_PARAM_ADDR, ~param, rdata, cycles);
                check_value("stalled write busy cycles", 64'(cycles), 64'd1);
            end
            wait_frame_end();
            mask = (64'd1 << n) - 64'd1;
            check_value("spi bit count", 64'(spi_nbits - nbits0), 64'(n));
            check_value("spi frames", 64'(frame_count - frames0), 64'd1);
            check_value("spi_mosi_o bits", spi_bits & mask, 64'(frame >> (32 - 8 * cnt)));
        end
        report_test("spi", errs0);
    endtask

    task automatic touch_read();
        logic [31:0] xy;
        logic [31:0] rdata;
        int          cycles;
        int          errs0;
        errs0 = errors;
        bus_access(1'b1, TOUCH_ADDR, 32'h0, rdata, cycles);
        check_value("rd_data_o while not ready", 64'(rdata), 64'd0);
        xy       = $random(seed);
        i2c_xy   = xy;
        i2c_done = 1'b1;
        @(posedge clk);
        #1;
        i2c_done = 1'b0;
        check_value("touch_ready_o", 64'(touch_ready), 64'd1);
        bus_access(1'b1, TOUCH_ADDR, 32'h0, rdata, cycles);
        check_value("touch busy cycles", 64'(cycles), 64'd1);
        check_value("rd_data_o", 64'(rdata), 64'(xy));
        check_value("touch_ready_o after read", 64'(touch_ready), 64'd0);
        // the held word is nonzero now, a second read must still stall
        bus_access(1'b1, TOUCH_ADDR, 32'h0, rdata, cycles);
        check_value("rd_data_o after consume", 64'(rdata), 64'd0);
        report_test("touch", errs0);
    endtask

    task automatic stall_unmapped();
        logic [31:0] rdata;
        int          cycles;
        int          errs0;
        errs0 = errors;
        ram_model[904] = $random(seed);     // 5000 folds onto 904 if decoded wrong
        bus_access(1'b0, 32'd904, ram_model[904], rdata, cycles);
        @(posedge clk);
        #1;
        bus_access(1'b0, 32'd5000, ~ram_model[904], rdata, cycles);
        check_value("unmapped busy cycles", 64'(cycles), 64'd1);
        check_value("rd_data_o unmapped", 64'(rdata), 64'd0);
        ram_model[17] = $random(seed);
        bus_access(1'b0, 32'd17, ram_model[17], rdata, cycles);
        bus_access(1'b1, 32'd17, 32'h0, rdata, cycles);     // ram still busy
        check_value("stalled read busy cycles", 64'(cycles), 64'd1);
        check_value("rd_data_o stalled", 64'(rdata), 64'd0);
        @(posedge clk);
        #1;
        bus_access(1'b1, 32'd904, 32'h0, rdata, cycles);
        check_value("rd_data_o word 904", 64'(rdata), 64'(ram_model[904]));
        bus_access(1'b1, 32'd17, 32'h0, rdata, cycles);
        check_value("rd_data_o word 17", 64'(rdata), 64'(ram_model[17]));
        report_test("stall", errs0);
    endtask

    initial begin
        nRst     = 1'b0;
        req      = '0;
        i2c_xy   = '0;
        i2c_done = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        nRst = 1'b1;
        reset_state();
        ram_roundtrip();
        spi_frame();
        touch_read();
        stall_unmapped();
        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* tests/mmio_decoder_asserts.sv */
`timescale 1ns/1ps

module mmio_decoder_asserts (
    input logic               clk,
    input logic               nRst,
    input logic               busy_o,
    input mmio_pkg::mem_req_t mem_req_o,
    input mmio_pkg::spi_cfg_t spi_cfg_o,
    input logic               spi_busy_i
);

    strobes_exclusive: assert property (@(posedge clk) disable iff (!nRst)
        !(mem_req_o.read && mem_req_o.write))
        else $error("ram read and write strobes are high together");

    // a ram read is the longest access, two busy cycles
    busy_bounded: assert property (@(posedge clk) disable iff (!nRst)
        (busy_o && $past(busy_o)) |=> !busy_o)
        else $error("busy stayed high for more than two cycles");

    start_when_idle: assert property (@(posedge clk) disable iff (!nRst)
        spi_cfg_o.start |-> !spi_busy_i)
        else $error("spi start pulsed while the spi port was busy");

endmodule

bind mmio_decoder mmio_decoder_asserts u_asserts (
    .clk        (clk),
    .nRst       (nRst),
    .busy_o     (busy_o),
    .mem_req_o  (mem_req_o),
    .spi_cfg_o  (spi_cfg_o),
    .spi_busy_i (spi_busy_i)
);

/* design/mmio_top.sv */
`timescale 1ns/1ps

module mmio_top (
    input  logic              clk,
    input  logic              nRst,
    input  mmio_pkg::mh_req_t req_i,
    input  logic [31:0]       i2c_xy_i,
    input  logic              i2c_done_i,
    output logic [31:0]       rd_data_o,
    output logic              busy_o,
    output logic              touch_ready_o,
    output logic              spi_sclk_o,
    output logic              spi_mosi_o,
    output logic              spi_cs_n_o
);

    import mmio_pkg::*;

    mem_req_t    mem_req;
    logic [31:0] mem_rdata;
    logic        mem_busy;
    spi_cfg_t    spi_cfg;
    logic        spi_busy;
    logic [31:0] touch_xy;
    logic        touch_consume;

    mmio_decoder u_decoder (
        .clk             (clk),
        .nRst            (nRst),
        .req_i           (req_i),
        .rd_data_o       (rd_data_o),
        .busy_o          (busy_o),
        .mem_req_o       (mem_req),
        .mem_rdata_i     (mem_rdata),
        .mem_busy_i      (mem_busy),
        .spi_cfg_o       (spi_cfg),
        .spi_busy_i      (spi_busy),
        .touch_xy_i      (touch_xy),
        .touch_ready_i   (touch_ready_o),   // also polled from outside
        .touch_consume_o (touch_consume)
    );

    data_ram u_ram (
        .clk     (clk),
        .nRst    (nRst),
        .req_i   (mem_req),
        .rdata_o (mem_rdata),
        .busy_o  (mem_busy)
    );

    spi_cmd_port u_spi (
        .clk    (clk),
        .nRst   (nRst),
        .cfg_i  (spi_cfg),
        .busy_o (spi_busy),
        .sclk_o (spi_sclk_o),
        .mosi_o (spi_mosi_o),
        .cs_n_o (spi_cs_n_o)
    );

    touch_capture u_touch (
        .clk        (clk),
        .nRst       (nRst),
        .i2c_xy_i   (i2c_xy_i),
        .i2c_done_i (i2c_done_i),
        .consume_i  (touch_consume),
        .xy_o       (touch_xy),
        .ready_o    (touch_ready_o)
    );

endmodule

/* design/mmio_decoder.sv */
`timescale 1ns/1ps

module mmio_decoder (
    input  logic                clk,
    input  logic                nRst,
    // requester side
    input  mmio_pkg::mh_req_t   req_i,
    output logic [31:0]         rd_data_o,
    output logic                busy_o,
    // data ram
    output mmio_pkg::mem_req_t  mem_req_o,
    input  logic [31:0]         mem_rdata_i,
    input  logic                mem_busy_i,
    // spi command port
    output mmio_pkg::spi_cfg_t  spi_cfg_o,
    input  logic                spi_busy_i,
    // touch capture
    input  logic [31:0]         touch_xy_i,
    input  logic                touch_ready_i,
    output logic                touch_consume_o
);

    import mmio_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        MEM_READ
    } state_t;

    state_t        state_q, state_n;
    logic [31:0]   rd_data_n;
    logic          busy_n;
    mem_req_t      mem_req_n;
    spi_cfg_t      spi_cfg_n;
    logic          consume_n;
    spi_cmd_word_u cmd_word;

    logic          one_cmd;     // exactly one of read / write
    logic          hit_ram;
    logic          hit_cmd;
    logic          hit_param;
    logic          hit_touch;

    assign cmd_word.raw = req_i.data;

    assign one_cmd   = req_i.read ^ req_i.write;
    assign hit_ram   = req_i.address < 32'(MEM_WORDS);
    assign hit_cmd   = req_i.write && (req_i.address == SPI_CMD_ADDR);
    assign hit_param = req_i.write && (req_i.address == SPI_PARAM_ADDR);
    assign hit_touch = req_i.read && (req_i.address == TOUCH_ADDR);

    always_comb begin
        state_n         = IDLE;
        busy_n          = 1'b0;
        rd_data_n       = '0;         // zero outside the data cycle
        mem_req_n       = '0;
        spi_cfg_n       = spi_cfg_o;  // command, count, params are held
        spi_cfg_n.start = 1'b0;
        consume_n       = 1'b0;

        case (state_q)
            IDLE: begin
                if (one_cmd) begin
                    // stall and unmapped fall through with one busy cycle
                    busy_n  = 1'b1;
                    state_n = BUSY;
                    if (hit_ram) begin
                        if (!mem_busy_i) begin
                            mem_req_n.read    = req_i.read;
                            mem_req_n.write   = req_i.write;
                            mem_req_n.address = req_i.address;
                            mem_req_n.data    = req_i.data;
                            if (req_i.read)
                                state_n = MEM_READ;
                        end
                    end else if (hit_cmd) begin
                        spi_cfg_n.command = cmd_word.fields.command;
                        spi_cfg_n.count   = cmd_word.fields.count;
                    end else if (hit_param) begin
                        if (!spi_busy_i) begin
                            spi_cfg_n.parameters = req_i.data;
                            spi_cfg_n.start      = 1'b1;
                        end
                    end else if (hit_touch) begin
                        if (touch_ready_i) begin
                            rd_data_n = touch_xy_i;
                            consume_n = 1'b1;
                        end
                    end
                end
            end
            MEM_READ: begin
                // ram word is valid now, hand it out next cycle
                busy_n    = 1'b1;
                rd_data_n = mem_rdata_i;
                state_n   = BUSY;
            end
            default: begin
                state_n = IDLE;   // busy drops
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state_q         <= IDLE;
            rd_data_o       <= '0;
            busy_o          <= 1'b0;
            mem_req_o       <= '0;
            spi_cfg_o       <= '0;
            touch_consume_o <= 1'b0;
        end else begin
            state_q         <= state_n;
            rd_data_o       <= rd_data_n;
            busy_o          <= busy_n;
            mem_req_o       <= mem_req_n;
            spi_cfg_o       <= spi_cfg_n;
            touch_consume_o <= consume_n;
        end
    end

endmodule

/* design/touch_capture.sv */
`timescale 1ns/1ps

module touch_capture (
    input  logic        clk,
    input  logic        nRst,
    input  logic [31:0] i2c_xy_i,
    input  logic        i2c_done_i,
    input  logic        consume_i,
    output logic [31:0] xy_o,
    output logic        ready_o
);

    // coordinate word, only read while ready is set
    always_ff @(posedge clk) begin
        if (i2c_done_i)
            xy_o <= i2c_xy_i;
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst)
            ready_o <= 1'b0;
        else if (i2c_done_i)
            ready_o <= 1'b1;    // a new word beats a consume in the same cycle
        else if (consume_i)
            ready_o <= 1'b0;
    end

endmodule

/* design/spi_cmd_port.sv */
`timescale 1ns/1ps

module spi_cmd_port (
    input  logic               clk,
    input  logic               nRst,
    input  mmio_pkg::spi_cfg_t cfg_i,
    output logic               busy_o,
    output logic               sclk_o,
    output logic               mosi_o,
    output logic               cs_n_o
);

    import mmio_pkg::*;

    logic [SPI_FRAME_BITS-1:0] shreg;       // command byte then parameter bytes, msb first
    logic [SPI_CNT_W-1:0]      bits_left;
    logic [SPI_CNT_W-1:0]      frame_bits;
    logic [3:0]                cnt_lim;

    // no more than four parameter bytes per frame
    assign cnt_lim    = (cfg_i.count > SPI_MAX_BYTES) ? SPI_MAX_BYTES : cfg_i.count;
    assign frame_bits = SPI_CNT_W'(8) + SPI_CNT_W'({cnt_lim[2:0], 3'b000});

    assign mosi_o = shreg[SPI_FRAME_BITS-1];

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            busy_o    <= 1'b0;
            cs_n_o    <= 1'b1;
            sclk_o    <= 1'b0;
            shreg     <= '0;
            bits_left <= '0;
        end else if (!busy_o) begin
            if (cfg_i.start) begin
                busy_o    <= 1'b1;
                cs_n_o    <= 1'b0;
                sclk_o    <= 1'b0;
                shreg     <= {cfg_i.command, cfg_i.parameters};
                bits_left <= frame_bits;
            end
        end else if (!sclk_o) begin
            sclk_o <= 1'b1;                      // receiver samples here, mosi is steady
        end else begin
            sclk_o    <= 1'b0;
            shreg     <= shreg << 1;             // next bit goes out while sclk is low
            bits_left <= bits_left - 1'b1;
            if (bits_left == SPI_CNT_W'(1)) begin
                // last bit done
                busy_o <= 1'b0;
                cs_n_o <= 1'b1;
            end
        end
    end

endmodule

/* design/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic               clk,
    input  logic               nRst,
    input  mmio_pkg::mem_req_t req_i,
    output logic [31:0]        rdata_o,
    output logic               busy_o
);

    import mmio_pkg::*;

    logic [31:0] mem [MEM_WORDS];

    assign rdata_o = mem[req_i.address[MEM_AW-1:0]];   // combinational read

    always_ff @(posedge clk) begin
        if (req_i.write)
            mem[req_i.address[MEM_AW-1:0]] <= req_i.data;
    end

    // one busy cycle after every access
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst)
            busy_o <= 1'b0;
        else
            busy_o <= req_i.read | req_i.write;
    end

endmodule

/* design/mmio_pkg.sv */
package mmio_pkg;

    // address map
    localparam int          MEM_WORDS      = 2048;              // ram depth, also the ram range bound
    localparam int          MEM_AW         = $clog2(MEM_WORDS);
    localparam logic [31:0] SPI_CMD_ADDR   = 32'd121212;        // command byte + byte counter
    localparam logic [31:0] SPI_PARAM_ADDR = 32'd333333;        // parameter word, starts a frame
    localparam logic [31:0] TOUCH_ADDR     = 32'd923923;        // latest i2c x/y word

    // spi frame limits
    localparam logic [3:0]  SPI_MAX_BYTES  = 4'd4;
    localparam int          SPI_FRAME_BITS = 8 + 8 * 4;         // command + max parameter bytes
    localparam int          SPI_CNT_W      = $clog2(SPI_FRAME_BITS + 1);

    // requester command
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] address;
        logic [31:0] data;
    } mh_req_t;

    // decoder to ram
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] address;
        logic [31:0] data;
    } mem_req_t;

    // decoder to spi port
    typedef struct packed {
        logic [31:0] parameters;
        logic [7:0]  command;
        logic [3:0]  count;
        logic        start;     // one-cycle pulse
    } spi_cfg_t;

    // word written to SPI_CMD_ADDR, seen raw or as fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [19:0] reserved;
            logic [3:0]  count;
            logic [7:0]  command;
        } fields;
    } spi_cmd_word_u;

endpackage
